/* Makefile */
# Verilator simulation of the data cache testbench

TOP := dcache_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f dcache_top.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Some tests failed" sim.log; then exit 1; fi
	@grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* dcache_top.f */
+incdir+include
source/dcache_pkg.sv
source/dcache_array_if.sv
source/dcache_line_array.sv
source/dcache_controller.sv
source/dcache_top.sv
dv/dcache_assertions.sv
dv/dcache_tb.sv

/* dv/dcache_assertions.sv */
// Concurrent checks on the controller's bus and core handshakes
// Bound to every dcache_controller instance
`timescale 1ns/1ps
`default_nettype none

module dcache_assertions (
	input logic                  clk,
	input logic                  rst_i,
	input logic                  rd_i,
	input logic                  wr_i,
	input logic                  rdy_o,
	input logic                  cyc_o,
	input logic                  stb_o,
	input logic [2:0]            cti_o,
	input dcache_pkg::dc_state_e state
);

	// Strobe only inside a bus cycle
	stb_in_cyc: assert property (@(posedge clk) disable iff (rst_i) stb_o |-> cyc_o)
		else $error("stb_o high without cyc_o");

	// Ready only answers a held request
	rdy_with_req: assert property (@(posedge clk) disable iff (rst_i)
		rdy_o |-> (rd_i || wr_i))
		else $error("rdy_o high with no read or write request");

	// Burst opens as incrementing
	burst_start: assert property (@(posedge clk) disable iff (rst_i)
		$rose(cyc_o) |-> (stb_o && cti_o == 3'b010))
		else $error("bus cycle did not open as an incrementing burst");

	// FSM leaves reset in IDLE
	idle_after_rst: assert property (@(posedge clk)
		$fell(rst_i) |-> (state == dcache_pkg::IDLE))
		else $error("controller not in IDLE after reset");

endmodule

bind dcache_controller dcache_assertions i_dcache_assertions (
	.clk  (clk),
	.rst_i(rst_i),
	.rd_i (rd_i),
	.wr_i (wr_i),
	.rdy_o(rdy_o),
	.cyc_o(cyc_o),
	.stb_o(stb_o),
	.cti_o(cti_o),
	.state(state)
);

`default_nettype wire

/* dv/dcache_tb.sv */
// Self-checking testbench for the data cache subsystem
// Memory returns address XOR A5A5_0000; bus wait states come from a seeded $random
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defs.svh"

module dcache_tb;

	localparam int NUM_TESTS   = 13;
	localparam int CYCLE_LIMIT = 200 * NUM_TESTS;
	localparam int OP_RD       = 0;
	localparam int OP_WR       = 1;
	localparam int OP_INV      = 2;

	// Cycles from the request cycle to rdy_o, fixed wherever no bus fill is involved
	localparam int LAT_ANY    = -1;
	localparam int LAT_HIT    = 0;
	localparam int LAT_WR_HIT = `DC_L1_WR_LAT + 1;
	localparam int LAT_L2_HIT = `DC_L2_RD_LAT + 2 + `DC_L1_WR_LAT + 1;

	logic               clk;
	logic               rst_i;
	logic               rd_i;
	logic               wr_i;
	logic [`DC_ABW-1:0] adr_i;
	logic [3:0]         wsel_i;
	logic [31:0]        wdat_i;
	logic               rdy_o;
	logic [31:0]        rdat_o;
	logic               fault_o;
	logic               inval_i;
	logic [`DC_ABW-1:0] inval_adr_i;
	logic               cyc_o;
	logic               stb_o;
	logic [2:0]         cti_o;
	logic [`DC_ABW-1:0] adr_o;
	// Driven by the memory model only
	logic               ack_i = 1'b0;
	logic               err_i = 1'b0;
	logic [31:0]        dat_i = 32'h0;
	logic [15:0]        fill_count_o;

	// Stimulus table, one column per field
	int                 t_op   [NUM_TESTS];
	logic [`DC_ABW-1:0] t_adr  [NUM_TESTS];
	logic [31:0]        t_wdat [NUM_TESTS];
	logic [3:0]         t_wsel [NUM_TESTS];
	logic [3:0]         t_err  [NUM_TESTS];
	logic [31:0]        t_dat  [NUM_TESTS];
	logic               t_flt  [NUM_TESTS];
	logic [15:0]        t_fill [NUM_TESTS];
	int                 t_lat  [NUM_TESTS];

	integer     seed = 32'h4f82;
	int         cycles;
	int         errors;
	int         passed;
	// Beats of the current burst that answer with err_i
	logic [3:0] err_beats;
	int         beat;
	// Burst protocol violations seen by the memory model
	int         bus_errors = 0;

	dcache_top i_dcache_top (
		.clk         (clk),
		.rst_i       (rst_i),
		.rd_i        (rd_i),
		.wr_i        (wr_i),
		.adr_i       (adr_i),
		.wsel_i      (wsel_i),
		.wdat_i      (wdat_i),
		.rdy_o       (rdy_o),
		.rdat_o      (rdat_o),
		.fault_o     (fault_o),
		.inval_i     (inval_i),
		.inval_adr_i (inval_adr_i),
		.cyc_o       (cyc_o),
		.stb_o       (stb_o),
		.cti_o       (cti_o),
		.adr_o       (adr_o),
		.ack_i       (ack_i),
		.err_i       (err_i),
		.dat_i       (dat_i),
		.fill_count_o(fill_count_o)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ========================================================================
	// Memory burst model
	// ========================================================================
	always @(posedge clk) begin
		if (rst_i || !cyc_o) begin
			ack_i <= 1'b0;
			err_i <= 1'b0;
			beat  <= 0;
		end else if (ack_i || err_i) begin
			// Idle cycle after each beat so adr_o has advanced
			ack_i <= 1'b0;
			err_i <= 1'b0;
		end else if (stb_o && ($random(seed) % 4 != 0)) begin
			// Last of the four beats is flagged end of burst, earlier ones incrementing
			if (cti_o !== ((beat == 3) ? 3'b111 : 3'b010)) begin
				$display("MISMATCH at %0t: cti_o %b on beat %0d", $time, cti_o, beat);
				bus_errors <= bus_errors + 1;
			end
			dat_i <= adr_o ^ 32'hA5A5_0000;
			beat  <= beat + 1;
			if (err_beats[beat[1:0]]) begin
				err_i <= 1'b1;
			end else begin
				ack_i <= 1'b1;
			end
		end
	end

	// Watchdog
	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: run did not complete within %0d cycles", CYCLE_LIMIT);
		$display("Some tests failed");
		$finish;
	end

	// ========================================================================
	// Core port tasks
	// ========================================================================
	task automatic add_entry(input int idx, input int op, input logic [31:0] adr,
			input logic [31:0] wdat, input logic [3:0] wsel, input logic [3:0] errb,
			input logic [31:0] dat, input logic flt, input logic [15:0] fill, input int lat);
		t_op[idx]   = op;
		t_adr[idx]  = adr;
		t_wdat[idx] = wdat;
		t_wsel[idx] = wsel;
		t_err[idx]  = errb;
		t_dat[idx]  = dat;
		t_flt[idx]  = flt;
		t_fill[idx] = fill;
		t_lat[idx]  = lat;
	endtask

	// Sampled on the falling edge, away from the driving edge
	// Zero cycles means rdy_o in the request cycle itself
	task automatic wait_ready(output int lat);
		lat = 0;
		@(negedge clk);
		while (!rdy_o) begin
			@(negedge clk);
			lat++;
		end
	endtask

	task automatic read_word(input logic [`DC_ABW-1:0] adr, output logic [31:0] dat,
			output logic flt, output int lat);
		@(posedge clk);
		rd_i  <= 1'b1;
		adr_i <= adr;
		wait_ready(lat);
		dat = rdat_o;
		flt = fault_o;
		@(posedge clk);
		rd_i <= 1'b0;
	endtask

	task automatic write_word(input logic [`DC_ABW-1:0] adr, input logic [31:0] dat,
			input logic [3:0] sel, output int lat);
		@(posedge clk);
		wr_i   <= 1'b1;
		adr_i  <= adr;
		wdat_i <= dat;
		wsel_i <= sel;
		wait_ready(lat);
		@(posedge clk);
		wr_i <= 1'b0;
	endtask

	// One-cycle pulse, then one idle cycle in which the controller serves it
	task automatic invalidate_line(input logic [`DC_ABW-1:0] adr);
		@(posedge clk);
		inval_i     <= 1'b1;
		inval_adr_i <= adr;
		@(posedge clk);
		inval_i <= 1'b0;
		@(posedge clk);
	endtask

	function automatic string op_name(input int op);
		if (op == OP_RD) begin
			return "read";
		end else if (op == OP_WR) begin
			return "write";
		end
		return "inval";
	endfunction

	// ========================================================================
	// Test sequence
	// ========================================================================
	initial begin : run_tests
		logic [31:0] rdat;
		logic        flt;
		logic        ok;
		int          lat;
		int          bus_errors_seen;

		rst_i       = 1'b1;
		rd_i        = 1'b0;
		wr_i        = 1'b0;
		adr_i       = '0;
		wsel_i      = 4'h0;
		wdat_i      = 32'h0;
		inval_i     = 1'b0;
		inval_adr_i = '0;
		err_beats   = 4'h0;
		errors      = 0;
		passed      = 0;
		bus_errors_seen = 0;

		// Cold miss, then hits on the same line
		add_entry(0, OP_RD, 32'h1004, 32'h0, 4'h0, 4'h0,
			32'hA5A5_1004, 1'b0, 16'd1, LAT_ANY);
		add_entry(1, OP_RD, 32'h1004, 32'h0, 4'h0, 4'h0,
			32'hA5A5_1004, 1'b0, 16'd1, LAT_HIT);
		add_entry(2, OP_RD, 32'h100C, 32'h0, 4'h0, 4'h0,
			32'hA5A5_100C, 1'b0, 16'd1, LAT_HIT);
		// Partial write hit, bytes 0 and 2
		add_entry(3, OP_WR, 32'h1008, 32'h1122_3344, 4'b0101, 4'h0,
			32'h0, 1'b0, 16'd1, LAT_WR_HIT);
		add_entry(4, OP_RD, 32'h1008, 32'h0, 4'h0, 4'h0,
			32'hA522_1044, 1'b0, 16'd1, LAT_HIT);
		// Invalidate L1, refill from L2
		add_entry(5, OP_INV, 32'h1000, 32'h0, 4'h0, 4'h0,
			32'h0, 1'b0, 16'd1, LAT_ANY);
		add_entry(6, OP_RD, 32'h1008, 32'h0, 4'h0, 4'h0,
			32'hA522_1044, 1'b0, 16'd1, LAT_L2_HIT);
		// Same L1 index, different L2 index; third read hits L2
		add_entry(7, OP_RD, 32'h2014, 32'h0, 4'h0, 4'h0,
			32'hA5A5_2014, 1'b0, 16'd2, LAT_ANY);
		add_entry(8, OP_RD, 32'h211C, 32'h0, 4'h0, 4'h0,
			32'hA5A5_211C, 1'b0, 16'd3, LAT_ANY);
		add_entry(9, OP_RD, 32'h2018, 32'h0, 4'h0, 4'h0,
			32'hA5A5_2018, 1'b0, 16'd3, LAT_L2_HIT);
		// Bus error on the second beat
		add_entry(10, OP_RD, 32'h3008, 32'h0, 4'h0, 4'b0010,
			32'h0, 1'b1, 16'd3, LAT_ANY);
		// Write miss is dropped
		add_entry(11, OP_WR, 32'h4004, 32'hDEAD_BEEF, 4'hF, 4'h0,
			32'h0, 1'b0, 16'd3, LAT_HIT);
		add_entry(12, OP_RD, 32'h4004, 32'h0, 4'h0, 4'h0,
			32'hA5A5_4004, 1'b0, 16'd4, LAT_ANY);

		repeat (2) @(posedge clk);
		rst_i <= 1'b0;

		for (int i = 0; i < NUM_TESTS; i++) begin
			ok = 1'b1;
			lat = LAT_ANY;
			err_beats <= t_err[i];
			if (t_op[i] == OP_RD) begin
				read_word(t_adr[i], rdat, flt, lat);
				if (flt !== t_flt[i]) begin
					$display("MISMATCH at %0t: test %0d fault_o %b, expected %b",
						$time, i, flt, t_flt[i]);
					ok = 1'b0;
				end
				// Data of a faulted line carries no meaning
				if (!t_flt[i] && rdat !== t_dat[i]) begin
					$display("MISMATCH at %0t: test %0d rdat_o %h, expected %h",
						$time, i, rdat, t_dat[i]);
					ok = 1'b0;
				end
			end else if (t_op[i] == OP_WR) begin
				write_word(t_adr[i], t_wdat[i], t_wsel[i], lat);
			end else begin
				invalidate_line(t_adr[i]);
			end
			if (t_lat[i] != LAT_ANY && lat != t_lat[i]) begin
				$display("MISMATCH at %0t: test %0d latency %0d, expected %0d",
					$time, i, lat, t_lat[i]);
				ok = 1'b0;
			end
			@(negedge clk);
			if (fill_count_o !== t_fill[i]) begin
				$display("MISMATCH at %0t: test %0d fill_count_o %0d, expected %0d",
					$time, i, fill_count_o, t_fill[i]);
				ok = 1'b0;
			end
			if (bus_errors != bus_errors_seen) begin
				bus_errors_seen = bus_errors;
				ok = 1'b0;
			end
			if (ok) begin
				passed++;
			end else begin
				errors++;
			end
			$display("test %0d %s %h: %s", i, op_name(t_op[i]), t_adr[i],
				ok ? "ok" : "FAILED");
		end

		$display("%0d tests run, %0d passed, %0d failed", NUM_TESTS, passed, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* include/dcache_defs.svh */
// Sizing and timing constants for the data cache subsystem
// Line size is fixed at 16 bytes; index widths must leave room for a tag in DC_ABW
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// ===========================================================================
// Address and array geometry
// ===========================================================================

// Byte address width of the core port and the memory bus
`define DC_ABW 32

// L1 index width, 16 lines
`define DC_L1_IDX 4

// L2 index width, 64 lines
`define DC_L2_IDX 6

// ===========================================================================
// Latencies in clock cycles
// ===========================================================================

// Wait before the L2 hit is trusted
`define DC_L2_RD_LAT 3

// Wait after an L1 write before the core is released
`define DC_L1_WR_LAT 3

`endif

/* source/dcache_array_if.sv */
// Lookup and write bundle between the controller and one cache array
// hit and rdata are combinational from adr; wr and inval act on the next clock edge
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defs.svh"

interface dcache_array_if #(
	parameter type PAYLOAD_T = dcache_pkg::line_data_t
) ();

	// Line address, offset bits are ignored by the array
	logic [`DC_ABW-1:0] adr;
	logic               hit;
	PAYLOAD_T           rdata;
	// One-cycle write strobe with byte mask over the line data
	logic               wr;
	logic [15:0]        wsel;
	PAYLOAD_T           wdata;
	// One-cycle valid clear
	logic               inval;

	modport controller (output adr, wr, wsel, wdata, inval, input hit, rdata);

	modport array (input adr, wr, wsel, wdata, inval, output hit, rdata);

endinterface

`default_nettype wire

/* source/dcache_controller.sv */
// Blocking cache controller: one core request at a time, L2 checked before a bus fill
// Write misses are dropped; only L1 is invalidated; a bus error ends the fill early
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defs.svh"

module dcache_controller (
	input  logic               clk,
	input  logic               rst_i,
	// Core port
	input  logic               rd_i,
	input  logic               wr_i,
	input  logic [`DC_ABW-1:0] adr_i,
	input  logic [3:0]         wsel_i,
	input  logic [31:0]        wdat_i,
	output logic               rdy_o,
	output logic [31:0]        rdat_o,
	output logic               fault_o,
	// Line invalidate
	input  logic               inval_i,
	input  logic [`DC_ABW-1:0] inval_adr_i,
	// Burst bus master
	output logic               cyc_o,
	output logic               stb_o,
	output logic [2:0]         cti_o,
	output logic [`DC_ABW-1:0] adr_o,
	input  logic               ack_i,
	input  logic               err_i,
	input  logic [31:0]        dat_i,
	output logic [15:0]        fill_count_o,
	// Arrays
	dcache_array_if.controller l1,
	dcache_array_if.controller l2
);

	// Cycle type identifiers
	localparam logic [2:0] CTI_CLASSIC = 3'b000;
	localparam logic [2:0] CTI_INCR    = 3'b010;
	localparam logic [2:0] CTI_EOB     = 3'b111;

	dcache_pkg::dc_state_e  state;
	logic [2:0]             cnt;
	logic                   inval_pend;
	logic                   fill_err;
	dcache_pkg::addr_t      inval_line;
	dcache_pkg::addr_t      line_adr;
	dcache_pkg::addr_t      req_line;
	dcache_pkg::addr_t      cur_line;
	dcache_pkg::line_data_t fill_buf;

	// Line base of the request, taken live in IDLE and held afterwards
	assign req_line = {adr_i[`DC_ABW-1:4], 4'h0};
	assign cur_line = (state == dcache_pkg::IDLE) ? req_line : line_adr;

	// Word select by address bits 3:2
	assign rdat_o  = l1.rdata.data[adr_i[3:2]];
	assign fault_o = rdy_o && rd_i && (l1.rdata.fault != dcache_pkg::FLT_NONE);

	// ===========================================================================
	// Array strobes and core ready
	// ===========================================================================
	always_comb begin
		l1.adr         = cur_line;
		l1.wr          = 1'b0;
		l1.wsel        = 16'hFFFF;
		l1.wdata.data  = l2.rdata;
		l1.wdata.fault = dcache_pkg::FLT_NONE;
		l1.inval       = 1'b0;
		l2.adr         = cur_line;
		l2.wr          = 1'b0;
		l2.wsel        = 16'hFFFF;
		l2.wdata       = fill_buf;
		l2.inval       = 1'b0;
		rdy_o          = 1'b0;
		case (state)
		dcache_pkg::IDLE: begin
			if (inval_pend) begin
				// Invalidate goes first and holds off the core for this cycle
				l1.adr   = inval_line;
				l1.inval = 1'b1;
			end else if (wr_i) begin
				// L1 is a subset of L2, so an L1 hit updates both levels
				rdy_o          = !l1.hit;
				l1.wr          = l1.hit;
				l2.wr          = l1.hit;
				l1.wsel        = 16'(wsel_i) << {adr_i[3:2], 2'b00};
				l2.wsel        = 16'(wsel_i) << {adr_i[3:2], 2'b00};
				l1.wdata.data  = {4{wdat_i}};
				l1.wdata.fault = l1.rdata.fault;
				l2.wdata       = {4{wdat_i}};
			end else if (rd_i) begin
				rdy_o = l1.hit;
			end
		end
		dcache_pkg::L2_CHECK: begin
			// L2 hit copies the whole line into L1
			l1.wr = l2.hit;
		end
		dcache_pkg::FILL_WR: begin
			l1.wr = 1'b1;
			l2.wr = !fill_err;
			if (fill_err) begin
				l1.wdata.data  = '0;
				l1.wdata.fault = dcache_pkg::FLT_BUS_ERR;
			end else begin
				l1.wdata.data = fill_buf;
			end
		end
		dcache_pkg::WR_SETTLE: begin
			rdy_o = (cnt == 3'(`DC_L1_WR_LAT)) && (rd_i || wr_i);
		end
		default: begin
			rdy_o = 1'b0;
		end
		endcase
	end

	// ===========================================================================
	// FSM, bus control and fill counter
	// ===========================================================================
	always_ff @(posedge clk) begin
		if (rst_i) begin
			state        <= dcache_pkg::IDLE;
			cnt          <= '0;
			inval_pend   <= 1'b0;
			fill_err     <= 1'b0;
			cyc_o        <= 1'b0;
			stb_o        <= 1'b0;
			cti_o        <= CTI_CLASSIC;
			fill_count_o <= '0;
		end else begin
			// A new request overrides one being served this cycle
			if (state == dcache_pkg::IDLE && inval_pend) begin
				inval_pend <= 1'b0;
			end
			if (inval_i) begin
				inval_pend <= 1'b1;
			end
			case (state)
			dcache_pkg::IDLE: begin
				cnt <= '0;
				if (!inval_pend && rd_i && !l1.hit) begin
					state <= dcache_pkg::L2_WAIT;
				end else if (!inval_pend && wr_i && l1.hit) begin
					state <= dcache_pkg::WR_SETTLE;
				end
			end
			dcache_pkg::L2_WAIT: begin
				cnt <= cnt + 3'd1;
				if (cnt == 3'(`DC_L2_RD_LAT)) begin
					cnt   <= '0;
					state <= dcache_pkg::L2_CHECK;
				end
			end
			dcache_pkg::L2_CHECK: begin
				cnt <= '0;
				if (l2.hit) begin
					state <= dcache_pkg::WR_SETTLE;
				end else begin
					cyc_o    <= 1'b1;
					stb_o    <= 1'b1;
					cti_o    <= CTI_INCR;
					fill_err <= 1'b0;
					state    <= dcache_pkg::BUS_BURST;
				end
			end
			dcache_pkg::BUS_BURST: begin
				if (err_i) begin
					// First error ends the burst
					fill_err <= 1'b1;
					cyc_o    <= 1'b0;
					stb_o    <= 1'b0;
					cti_o    <= CTI_CLASSIC;
					state    <= dcache_pkg::FILL_WR;
				end else if (ack_i) begin
					cnt <= cnt + 3'd1;
					// Fourth beat is flagged end of burst
					if (cnt == 3'd2) begin
						cti_o <= CTI_EOB;
					end
					if (cnt == 3'd3) begin
						cyc_o <= 1'b0;
						stb_o <= 1'b0;
						cti_o <= CTI_CLASSIC;
						state <= dcache_pkg::FILL_WR;
					end
				end
			end
			dcache_pkg::FILL_WR: begin
				cnt <= '0;
				if (!fill_err) begin
					fill_count_o <= fill_count_o + 16'd1;
				end
				state <= dcache_pkg::WR_SETTLE;
			end
			dcache_pkg::WR_SETTLE: begin
				cnt <= cnt + 3'd1;
				if (cnt == 3'(`DC_L1_WR_LAT)) begin
					state <= dcache_pkg::IDLE;
				end
			end
			default: begin
				state <= dcache_pkg::IDLE;
			end
			endcase
		end
	end

	// Addresses and fill assembly
	always_ff @(posedge clk) begin
		if (inval_i) begin
			inval_line <= {inval_adr_i[`DC_ABW-1:4], 4'h0};
		end
		if (state == dcache_pkg::IDLE) begin
			line_adr <= req_line;
		end
		if (state == dcache_pkg::L2_CHECK) begin
			adr_o <= line_adr;
		end
		if (state == dcache_pkg::BUS_BURST && ack_i && !err_i) begin
			fill_buf[cnt[1:0]] <= dat_i;
			adr_o              <= adr_o + `DC_ABW'(4);
		end
	end

endmodule

`default_nettype wire

/* source/dcache_line_array.sv */
// Direct-mapped tag and payload store with 16-byte lines
// Payload bits above 127 are always written on wr; the byte mask covers bits 127:0
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defs.svh"

module dcache_line_array #(
	parameter type PAYLOAD_T = dcache_pkg::line_data_t,
	parameter int  IDX_W     = `DC_L1_IDX
) (
	input logic clk,
	input logic rst_i,
	dcache_array_if.array arr
);

	localparam int LINES = 1 << IDX_W;
	localparam int PW    = $bits(PAYLOAD_T);
	localparam int TAG_W = `DC_ABW - IDX_W - 4;

	// Storage
	logic [PW-1:0]    data_q [LINES];
	logic [TAG_W-1:0] tag_q  [LINES];
	logic [LINES-1:0] valid_q;

	// Address split
	logic [IDX_W-1:0] idx;
	logic [TAG_W-1:0] tag;

	// Bit mask built from the byte mask
	logic [PW-1:0]    wmask;
	logic [PW-1:0]    wbits;

	assign idx = arr.adr[IDX_W+3:4];
	assign tag = arr.adr[`DC_ABW-1:IDX_W+4];

	// Combinational lookup
	assign arr.hit   = valid_q[idx] && (tag_q[idx] == tag);
	assign arr.rdata = PAYLOAD_T'(data_q[idx]);

	assign wbits = arr.wdata;

	always_comb begin
		// Bits above the line data, if any, follow every write
		wmask = '1;
		for (int b = 0; b < 16; b++) begin
			wmask[b*8 +: 8] = {8{arr.wsel[b]}};
		end
	end

	// Payload and tag, merged under the byte mask
	always_ff @(posedge clk) begin
		if (arr.wr) begin
			data_q[idx] <= (data_q[idx] & ~wmask) | (wbits & wmask);
			tag_q[idx]  <= tag;
		end
	end

	// Valid bits
	always_ff @(posedge clk) begin
		if (rst_i) begin
			valid_q <= '0;
		end else begin
			if (arr.wr) begin
				valid_q[idx] <= 1'b1;
			end else if (arr.inval) begin
				valid_q[idx] <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

/* source/dcache_pkg.sv */
// Shared types of the data cache subsystem
// The L1 payload puts the fault code above the line data so byte masks cover bits 127:0
`default_nettype none

`include "dcache_defs.svh"

package dcache_pkg;

	// Byte address as seen by the core and the bus
	typedef logic [`DC_ABW-1:0] addr_t;

	// One cache line, four 32-bit words, word 0 at the low end
	typedef logic [3:0][31:0] line_data_t;

	// Fault code carried with each L1 line
	typedef enum logic [1:0] {
		FLT_NONE    = 2'd0,
		FLT_BUS_ERR = 2'd3
	} fault_e;

	// L1 entry: fault tag in the upper bits, data below
	typedef struct packed {
		fault_e     fault;
		line_data_t data;
	} l1_line_t;

	// Controller FSM states
	typedef enum logic [2:0] {
		IDLE,
		L2_WAIT,
		L2_CHECK,
		BUS_BURST,
		FILL_WR,
		WR_SETTLE
	} dc_state_e;

endpackage

`default_nettype wire

/* source/dcache_top.sv */
// Data cache subsystem: controller with a 16-line L1 and a 64-line L2
// Single bus master, reads only on the bus
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defs.svh"

module dcache_top (
	input  logic               clk,
	input  logic               rst_i,
	// Core port
	input  logic               rd_i,
	input  logic               wr_i,
	input  logic [`DC_ABW-1:0] adr_i,
	input  logic [3:0]         wsel_i,
	input  logic [31:0]        wdat_i,
	output logic               rdy_o,
	output logic [31:0]        rdat_o,
	output logic               fault_o,
	// Line invalidate
	input  logic               inval_i,
	input  logic [`DC_ABW-1:0] inval_adr_i,
	// Memory bus
	output logic               cyc_o,
	output logic               stb_o,
	output logic [2:0]         cti_o,
	output logic [`DC_ABW-1:0] adr_o,
	input  logic               ack_i,
	input  logic               err_i,
	input  logic [31:0]        dat_i,
	output logic [15:0]        fill_count_o
);

	// L1 carries a fault tag per line, L2 holds plain data
	dcache_array_if #(.PAYLOAD_T(dcache_pkg::l1_line_t))   l1_if ();
	dcache_array_if #(.PAYLOAD_T(dcache_pkg::line_data_t)) l2_if ();

	dcache_line_array #(
		.PAYLOAD_T(dcache_pkg::l1_line_t),
		.IDX_W    (`DC_L1_IDX)
	) i_l1_array (
		.clk  (clk),
		.rst_i(rst_i),
		.arr  (l1_if.array)
	);

	dcache_line_array #(
		.PAYLOAD_T(dcache_pkg::line_data_t),
		.IDX_W    (`DC_L2_IDX)
	) i_l2_array (
		.clk  (clk),
		.rst_i(rst_i),
		.arr  (l2_if.array)
	);

	dcache_controller i_controller (
		.clk         (clk),
		.rst_i       (rst_i),
		.rd_i        (rd_i),
		.wr_i        (wr_i),
		.adr_i       (adr_i),
		.wsel_i      (wsel_i),
		.wdat_i      (wdat_i),
		.rdy_o       (rdy_o),
		.rdat_o      (rdat_o),
		.fault_o     (fault_o),
		.inval_i     (inval_i),
		.inval_adr_i (inval_adr_i),
		.cyc_o       (cyc_o),
		.stb_o       (stb_o),
		.cti_o       (cti_o),
		.adr_o       (adr_o),
		.ack_i       (ack_i),
		.err_i       (err_i),
		.dat_i       (dat_i),
		.fill_count_o(fill_count_o),
		.l1          (l1_if.controller),
		.l2          (l2_if.controller)
	);

endmodule

`default_nettype wire
